// File: hw/lcdDraw_consts.svh
`ifndef LCD_DRAW_CONSTS_SVH
`define LCD_DRAW_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry.
////////////////////////////////////////////////////////////////////////////

`define FRAME_W 32 // Pixels per row.
`define FRAME_H 16 // Rows with row 0 at top.
`define ADDR_W  9  // Pixel word address width.

////////////////////////////////////////////////////////////////////////////
// RGB565 colours.
////////////////////////////////////////////////////////////////////////////

`define COLOR_BG   16'h0000 // Background.
`define COLOR_BAR  16'h07E0 // Green bar.
`define COLOR_MARK 16'hF800 // Red max marker.

// Command FIFO entries as a power of two.
`define CMD_FIFO_DEPTH 4

`endif

// File: hw/lcdDrawPkg.sv
`default_nettype none

package lcdDrawPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Draw command set.
    ////////////////////////////////////////////////////////////////////////////

    // Opcode of one draw command.
    typedef enum logic [1:0] {
        OpFill = 2'd0, // Whole frame in one colour.
        OpBar  = 2'd1, // One column with a bar from the bottom.
        OpMark = 2'd2  // Single marker pixel.
    } drawOp_t;

    // One queued command of 29 bits.
    // For Bar, level is the bar height (0..16).
    // For Mark, level is the target row (0..15).
    typedef struct packed {
        drawOp_t     op;
        logic [4:0]  col;         // Column of Bar and Mark.
        logic [4:0]  level;       // Height or row.
        logic [15:0] color;       // RGB565.
        logic        lastOfFrame; // Closes one refresh.
    } drawCmd_t;

endpackage

`default_nettype wire

// File: hw/drawSequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "lcdDraw_consts.svh"

module drawSequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [7:0]            cursorIndex,
    input  logic [31:0]           pulseCount,
    input  logic [15:0]           maxPulse,
    input  logic [2:0]            gainShift,
    input  logic                  cmdReady,
    input  logic                  frameDone,
    output logic                  cmdValid,
    output lcdDrawPkg::drawCmd_t  cmd
);

    typedef enum logic [2:0] {
        Boot,
        Clear,
        Bar,
        Mark,
        WaitFrame
    } seqState_t;

    seqState_t   state;
    logic        snapTake;
    logic [31:0] pulseScaled;
    logic [15:0] maxScaled;
    logic [4:0]  barLevelNext;
    logic [4:0]  markRowNext;
    logic [4:0]  barCol;   // Snapshot of cursor column.
    logic [4:0]  barLevel; // Snapshot of bar height.
    logic [4:0]  markRow;  // Snapshot of marker row.

    ////////////////////////////////////////////////////////////////////////////
    // Scale and clip the live inputs.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pulseScaled = pulseCount >> gainShift; // Gain divider.
        maxScaled   = maxPulse >> gainShift;
        if (pulseScaled > 32'(`FRAME_H)) begin
            barLevelNext = 5'(`FRAME_H); // Full column.
        end else begin
            barLevelNext = pulseScaled[4:0];
        end
        // Larger max sits higher, so the row counts down from the bottom.
        if (maxScaled > 16'(`FRAME_H - 1)) begin
            markRowNext = 5'd0;
        end else begin
            markRowNext = 5'(`FRAME_H - 1) - maxScaled[4:0];
        end
    end

    // Boot entry or end of a refresh.
    assign snapTake = en && ((state == Boot) || (state == WaitFrame && frameDone));

    always_ff @(posedge clk) begin
        if (snapTake) begin
            barCol   <= cursorIndex[4:0]; // Modulo FRAME_W.
            barLevel <= barLevelNext;
            markRow  <= markRowNext;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step machine.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= Boot;
        end else if (!en) begin
            state <= Boot; // Restart on enable.
        end else begin
            case (state)
                Boot:      state <= Clear;
                Clear:     state <= cmdReady ? Bar : Clear;
                Bar:       state <= cmdReady ? Mark : Bar;
                Mark:      state <= cmdReady ? WaitFrame : Mark;
                WaitFrame: state <= frameDone ? Bar : WaitFrame;
                default:   state <= Boot;
            endcase
        end
    end

    // Command follows the state and holds until accepted.
    always_comb begin
        cmdValid        = 1'b0;
        cmd.op          = lcdDrawPkg::OpFill;
        cmd.col         = 5'd0;
        cmd.level       = 5'd0;
        cmd.color       = `COLOR_BG;
        cmd.lastOfFrame = 1'b0;
        case (state)
            Clear: begin
                cmdValid = en; // Boot clear.
            end
            Bar: begin
                cmdValid  = en;
                cmd.op    = lcdDrawPkg::OpBar;
                cmd.col   = barCol;
                cmd.level = barLevel;
                cmd.color = `COLOR_BAR;
            end
            Mark: begin
                cmdValid        = en;
                cmd.op          = lcdDrawPkg::OpMark;
                cmd.col         = 5'(`FRAME_W - 1); // Last column.
                cmd.level       = markRow;
                cmd.color       = `COLOR_MARK;
                cmd.lastOfFrame = 1'b1; // Engine answers with frameDone.
            end
            default: begin
                cmdValid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/drawCmdFifo.sv
`timescale 1ns/1ns
`default_nettype none

module drawCmdFifo #(
    parameter type PayloadT = logic [7:0],
    parameter int  Depth    = 4 // Power of two.
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pushValid,
    input  PayloadT pushData,
    output logic    pushReady,
    output logic    popValid,
    output PayloadT popData,
    input  logic    pop
);

    localparam int PtrW = $clog2(Depth);

    PayloadT         mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count; // Occupancy 0..Depth.
    logic            full;
    logic            doPush;
    logic            doPop;

    assign full      = (count == (PtrW + 1)'(Depth));
    assign popValid  = (count != '0);
    assign pushReady = !full || pop; // Slot freed by a same-cycle pop.
    assign popData   = mem[rdPtr];   // Head entry.
    assign doPush    = pushValid && pushReady;
    assign doPop     = pop && popValid;

    // Storage.
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap on their own width.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/drawEngine.sv
`timescale 1ns/1ns
`default_nettype none
`include "lcdDraw_consts.svh"

module drawEngine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    popValid,
    input  lcdDrawPkg::drawCmd_t    popCmd,
    output logic                    pop,
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output logic [`ADDR_W-1:0]      adr,
    output logic [15:0]             datW,
    input  logic                    ack,
    output logic                    frameDone
);

    localparam int AddrW = `ADDR_W;
    localparam int RowW  = $clog2(`FRAME_H);

    typedef enum logic {
        Idle,
        Write
    } engState_t;

    engState_t            state;
    lcdDrawPkg::drawCmd_t cmdReg;  // Command being drawn.
    logic [AddrW-1:0]     pixIdx;  // Pixel counter within the region.
    logic [AddrW-1:0]     lastIdx;
    logic                 lastPix;
    logic [RowW-1:0]      row;
    logic [4:0]           barTop;  // First row painted with bar colour.

    ////////////////////////////////////////////////////////////////////////////
    // Region walk per opcode.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        row     = pixIdx[RowW-1:0];
        barTop  = 5'(`FRAME_H) - cmdReg.level;
        lastIdx = '0;
        adr     = pixIdx;           // Fill walks in address order.
        datW    = cmdReg.color;
        case (cmdReg.op)
            lcdDrawPkg::OpFill: begin
                lastIdx = AddrW'(`FRAME_W * `FRAME_H - 1);
            end
            lcdDrawPkg::OpBar: begin
                lastIdx = AddrW'(`FRAME_H - 1); // Top to bottom.
                adr     = AddrW'(row * `FRAME_W + cmdReg.col);
                if (5'(row) < barTop) begin
                    datW = `COLOR_BG; // Above the bar.
                end
            end
            default: begin
                adr = AddrW'(cmdReg.level[RowW-1:0] * `FRAME_W + cmdReg.col);
            end
        endcase
        lastPix = (pixIdx == lastIdx);
    end

    // Take the head at once when idle.
    assign pop = (state == Idle) && popValid;

    // Bus strobe straight from state.
    assign cyc = (state == Write);
    assign stb = (state == Write);
    assign we  = (state == Write); // Writes only.

    always_ff @(posedge clk) begin
        if (pop) begin
            cmdReg <= popCmd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transfer control.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= Idle;
            pixIdx    <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0; // Single-cycle pulse.
            case (state)
                Idle: begin
                    if (pop) begin
                        pixIdx <= '0;
                        state  <= Write;
                    end
                end
                Write: begin
                    if (ack) begin
                        if (lastPix) begin
                            state     <= Idle; // Pop again next cycle.
                            frameDone <= cmdReg.lastOfFrame;
                        end else begin
                            pixIdx <= pixIdx + 1'b1; // Next write follows directly.
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/lcdDrawTop.sv
`timescale 1ns/1ns
`default_nettype none
`include "lcdDraw_consts.svh"

module lcdDrawTop (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic [7:0]         cursorIndex,
    input  logic [31:0]        pulseCount,
    input  logic [15:0]        maxPulse,
    input  logic [2:0]         gainShift,
    output logic               cyc,
    output logic               stb,
    output logic               we,
    output logic [`ADDR_W-1:0] adr,
    output logic [15:0]        datW,
    input  logic               ack,
    output logic               frameDone
);

    // Sequencer to FIFO.
    logic                 cmdValid;
    logic                 cmdReady;
    lcdDrawPkg::drawCmd_t cmd;

    // FIFO to engine.
    logic                 popValid;
    logic                 pop;
    lcdDrawPkg::drawCmd_t popCmd;

    drawSequencer drawSequencer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .cursorIndex (cursorIndex),
        .pulseCount  (pulseCount),
        .maxPulse    (maxPulse),
        .gainShift   (gainShift),
        .cmdReady    (cmdReady),
        .frameDone   (frameDone), // Refresh handshake.
        .cmdValid    (cmdValid),
        .cmd         (cmd)
    );

    drawCmdFifo #(
        .PayloadT (lcdDrawPkg::drawCmd_t),
        .Depth    (`CMD_FIFO_DEPTH)
    ) drawCmdFifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pushValid (cmdValid),
        .pushData  (cmd),
        .pushReady (cmdReady),
        .popValid  (popValid),
        .popData   (popCmd),
        .pop       (pop)
    );

    drawEngine drawEngine_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .popValid  (popValid),
        .popCmd    (popCmd),
        .pop       (pop),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .datW      (datW),
        .ack       (ack),
        .frameDone (frameDone)
    );

endmodule

`default_nettype wire

// File: dv/lcdDraw_assertions.sv
`timescale 1ns/1ns
`default_nettype none
`include "lcdDraw_consts.svh"

module lcdDraw_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               cyc,
    input logic               stb,
    input logic               we,
    input logic [`ADDR_W-1:0] adr,
    input logic [15:0]        datW,
    input logic               ack,
    input logic               frameDone
);

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone classic write rules.
    ////////////////////////////////////////////////////////////////////////////

    stbInsideCyc: assert property (@(posedge clk) disable iff (!rst_n) stb |-> cyc)
        else $error("stb high without cyc.");

    writeOnly: assert property (@(posedge clk) disable iff (!rst_n) stb |-> we)
        else $error("stb high without we.");

    // Address and data held until the slave answers.
    holdUntilAck: assert property (@(posedge clk) disable iff (!rst_n)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(datW)))
        else $error("Write changed before ack.");

    donePulse: assert property (@(posedge clk) disable iff (!rst_n) frameDone |=> !frameDone)
        else $error("frameDone longer than one cycle.");

endmodule

bind drawEngine lcdDraw_assertions lcdDraw_assertions_inst (.*);

`default_nettype wire

// File: dv/tbLcdDraw.sv
`timescale 1ns/1ns
`default_nettype none
`include "lcdDraw_consts.svh"

module tbLcdDraw;

    localparam int FrameTimeout = 4000; // Cycles per refresh with the boot clear.
    localparam int NumFrames    = 12;

    logic               clk;
    logic               rst_n;
    logic               en;
    logic [7:0]         cursorIndex;
    logic [31:0]        pulseCount;
    logic [15:0]        maxPulse;
    logic [2:0]         gainShift;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [`ADDR_W-1:0] adr;
    logic [15:0]        datW;
    logic               ack;
    logic               frameDone;

    logic [31:0]        stimRng = 32'd71; // Input values.
    logic [31:0]        ackRng  = 32'd71; // Slave delays.
    logic [15:0]        frameMem [`FRAME_W * `FRAME_H]; // Slave memory.
    logic [15:0]        shadow   [`FRAME_W * `FRAME_H]; // Model frame.
    logic [`ADDR_W-1:0] expAdr [$]; // Expected writes in order.
    logic [15:0]        expDat [$];

    lcdDrawTop lcdDrawTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("ERR t=%0t %s actual=%0h expected=%0h",
                               $time, name, actual, expected));
        end
    endtask

    // Wide spread of magnitudes, so clipping and small bars both occur.
    task automatic randomizeInputs();
        logic [31:0] r;
        stimRng     = xorshift(stimRng);
        r           = stimRng;
        cursorIndex = r[7:0]; // Above 31 often.
        gainShift   = r[10:8];
        stimRng     = xorshift(stimRng);
        pulseCount  = stimRng >> r[15:11];
        stimRng     = xorshift(stimRng);
        maxPulse    = stimRng[15:0] >> r[19:16];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame model.
    ////////////////////////////////////////////////////////////////////////////

    function automatic int barHeightOf(input logic [31:0] pc, input logic [2:0] gs);
        logic [31:0] scaled;
        scaled = pc >> gs;
        if (scaled > 32'(`FRAME_H)) begin
            return `FRAME_H; // Clipped at full column.
        end
        return int'(scaled);
    endfunction

    function automatic int markRowOf(input logic [15:0] mp, input logic [2:0] gs);
        int scaled;
        scaled = int'(mp >> gs);
        if (scaled > `FRAME_H - 1) begin
            scaled = `FRAME_H - 1;
        end
        return `FRAME_H - 1 - scaled; // Row 0 at top.
    endfunction

    task automatic expectWrite(input int a, input logic [15:0] d);
        expAdr.push_back(`ADDR_W'(a));
        expDat.push_back(d);
        shadow[a] = d;
    endtask

    task automatic expectFill();
        for (int i = 0; i < `FRAME_W * `FRAME_H; i++) begin
            expectWrite(i, `COLOR_BG);
        end
    endtask

    // Bar then Mark, from the inputs currently driven.
    task automatic expectRefresh();
        int col;
        int h;
        col = int'(cursorIndex) % `FRAME_W;
        h   = barHeightOf(pulseCount, gainShift);
        for (int row = 0; row < `FRAME_H; row++) begin
            expectWrite(row * `FRAME_W + col, (row >= `FRAME_H - h) ? `COLOR_BAR : `COLOR_BG);
        end
        expectWrite(markRowOf(maxPulse, gainShift) * `FRAME_W + `FRAME_W - 1, `COLOR_MARK);
    endtask

    task automatic compareFrame();
        for (int i = 0; i < `FRAME_W * `FRAME_H; i++) begin
            checkValue($sformatf("frame[%0d]", i), 32'(frameMem[i]), 32'(shadow[i]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone memory slave.
    ////////////////////////////////////////////////////////////////////////////

    task automatic recordWrite();
        if (expAdr.size() == 0) begin
            abortRun("Wishbone write seen while no write was expected.");
        end else begin
            checkValue("cyc", 32'(cyc), 32'd1);
            checkValue("we", 32'(we), 32'd1);
            checkValue("adr", 32'(adr), 32'(expAdr.pop_front()));
            checkValue("datW", 32'(datW), 32'(expDat.pop_front()));
            frameMem[adr] = datW;
        end
    endtask

    initial begin : wbSlave
        int   waitCnt;
        logic done;
        ack     = 1'b0;
        waitCnt = 0;
        for (int i = 0; i < `FRAME_W * `FRAME_H; i++) begin
            frameMem[i] = 16'hC000 | 16'(i); // Not background anywhere.
        end
        forever begin
            @(negedge clk);
            done = stb && ack; // Completes at the next edge.
            if (done) begin
                recordWrite();
            end
            @(posedge clk);
            #2;
            if (done) begin
                ackRng  = xorshift(ackRng);
                waitCnt = int'(ackRng % 4); // 0 to 3 wait cycles.
            end
            if (stb && waitCnt == 0) begin
                ack = 1'b1;
            end else begin
                ack = 1'b0;
                if (stb) begin
                    waitCnt--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////

    // Fresh junk on the inputs in every cycle before frameDone.
    task automatic waitFrameDone();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            cycles++;
            if (!frameDone) begin
                randomizeInputs();
            end
        end while (!frameDone && cycles < FrameTimeout);
        if (!frameDone) begin
            abortRun("Timeout: no frameDone within the refresh limit.");
        end
    endtask

    initial begin
        en          = 1'b0;
        cursorIndex = 8'd0;
        pulseCount  = 32'd0;
        maxPulse    = 16'd0;
        gainShift   = 3'd0;
        rst_n       = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (4) begin // Bus quiet before enable.
            @(posedge clk);
            #2;
            checkValue("cyc", 32'(cyc), 32'd0);
            checkValue("stb", 32'(stb), 32'd0);
            checkValue("frameDone", 32'(frameDone), 32'd0);
        end
        randomizeInputs(); // Boot snapshot.
        en = 1'b1;
        expectFill();
        expectRefresh();
        for (int frame = 0; frame < NumFrames; frame++) begin
            waitFrameDone();
            checkValue("pending writes", 32'(expAdr.size()), 32'd0);
            compareFrame();
            randomizeInputs(); // Held through the snapshot edge.
            expectRefresh();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/lcdDrawPkg.sv
hw/drawSequencer.sv
hw/drawCmdFifo.sv
hw/drawEngine.sv
hw/lcdDrawTop.sv
dv/lcdDraw_assertions.sv
dv/tbLcdDraw.sv

// File: run.sh
#!/bin/sh
# Verilator build and run. Exit status is the test result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tbLcdDraw -o simLcdDraw &&
./obj_dir/simLcdDraw || exit 1
